// ==== tb.f ====
hw/panel_pkg.sv
hw/key_debounce.sv
hw/spi_slave.sv
hw/dec_formatter.sv
hw/seg_scan.sv
hw/panel_top.sv
tb/tb_clk_gen.sv
tb/panel_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build panel_tb with Verilator, run it, and look for the pass line in the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
EXE=panel_sim

verilator --binary --timing --assert -Wno-fatal \
	-f tb.f --top-module panel_tb --Mdir obj_dir -o "$EXE"
status=$?
if [ $status -ne 0 ]; then
	echo "verilator build returned status $status"
	exit 1
fi

./obj_dir/"$EXE" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation returned status $status"
	exit 1
fi

if grep -qx "test passed" "$LOG"; then
	exit 0
else
	echo "pass line not found in $LOG"
	exit 1
fi

// ==== tb/panel_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// table-driven testbench for panel_top
// spi master task, key press and glitch stimulus, display scan sampling
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module panel_tb;
	import panel_pkg::*;

	localparam int KIND_SPI    = 0;
	localparam int KIND_KEY    = 1;
	localparam int KIND_GLITCH = 2;
	localparam int MAX_ROWS    = 16;
	localparam int HALF_SCLK   = 8;		// sys_clk cycles per sclk half period
	localparam int PRESS_HOLD  = 30;	// well past the debounce window
	localparam int GLITCH_KEY  = 2;
	localparam int SCAN_LIMIT  = NUM_DIGITS * SCAN_CYCLES + 4;

	logic                  sys_clk;
	logic                  sys_rst_n;
	key_t                  key_in;
	key_t                  led;
	logic                  cs;
	logic                  sclk;
	logic                  mosi;
	logic                  miso;
	seg_t                  seg_number;
	logic [NUM_DIGITS-1:0] seg_choice;

	// one row per step
	string  row_name [MAX_ROWS];
	int     row_kind [MAX_ROWS];
	int     row_arg  [MAX_ROWS];	// key index or glitch length
	byte_t  row_tx   [MAX_ROWS];
	byte_t  row_miso [MAX_ROWS];
	key_t   row_led  [MAX_ROWS];
	digit_t row_dig  [MAX_ROWS][3];
	int     n_rows;

	// reference state while the table is filled
	byte_t model_reply;
	key_t  model_led;
	byte_t model_disp;

	seg_t   glyph [11];
	integer seed;
	int     test_errs;
	int     tests_ok;
	int     tests_bad;

	tb_clk_gen u_clk_gen (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n)
	);

	panel_top u_dut (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.key_in     (key_in),
		.led        (led),
		.cs         (cs),
		.sclk       (sclk),
		.mosi       (mosi),
		.miso       (miso),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

	// position 0 units, 1 tens, 2 hundreds
	function automatic digit_t dec_digit(input byte_t value, input int pos);
		int rest;
		int hund;
		int ten;
		rest = value;
		hund = 0;
		ten  = 0;
		while (rest >= 100) begin
			rest -= 100;
			hund++;
		end
		while (rest >= 10) begin
			rest -= 10;
			ten++;
		end
		case (pos)
			0:       dec_digit = digit_t'(rest);
			1:       dec_digit = (hund == 0 && ten == 0) ? DIGIT_BLANK : digit_t'(ten);
			default: dec_digit = (hund == 0) ? DIGIT_BLANK : digit_t'(hund);
		endcase
	endfunction

	task automatic add_row(input string name, input int kind, input int arg, input byte_t tx);
		row_name[n_rows] = name;
		row_kind[n_rows] = kind;
		row_arg[n_rows]  = arg;
		row_tx[n_rows]   = tx;
		row_miso[n_rows] = model_reply;	// reply to the frame before
		if (kind == KIND_SPI) begin
			model_reply = tx + 8'd2;
			model_disp  = tx;
		end else if (kind == KIND_KEY) begin
			model_led[arg] = ~model_led[arg];
		end
		row_led[n_rows] = model_led;
		for (int k = 0; k < 3; k++)
			row_dig[n_rows][k] = dec_digit(model_disp, k);
		n_rows++;
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	// mode 3 master drives on falling sclk and samples on rising
	task automatic spi_transfer(input byte_t tx, output byte_t rx);
		rx = '0;
		@(posedge sys_clk);
		cs <= 1'b0;
		wait_cycles(HALF_SCLK);
		for (int b = 7; b >= 0; b--) begin
			@(posedge sys_clk);
			sclk <= 1'b0;
			mosi <= tx[b];
			wait_cycles(HALF_SCLK - 1);
			@(posedge sys_clk);
			sclk <= 1'b1;
			rx = {rx[6:0], miso};	// settled since the falling edge
			wait_cycles(HALF_SCLK - 1);
		end
		@(posedge sys_clk);
		cs <= 1'b1;
		wait_cycles(HALF_SCLK);		// frame gap until the byte lands on the display
	endtask

	task automatic press_key(input int idx);
		@(posedge sys_clk);
		key_in[idx] <= 1'b0;
		wait_cycles(PRESS_HOLD);
		key_in[idx] <= 1'b1;
		wait_cycles(PRESS_HOLD);
	endtask

	task automatic glitch_key(input int len);
		@(posedge sys_clk);
		key_in[GLITCH_KEY] <= 1'b0;
		wait_cycles(len);
		key_in[GLITCH_KEY] <= 1'b1;
		wait_cycles(PRESS_HOLD);
	endtask

	task automatic check_value(input string name, input string what, input byte_t exp,
			input byte_t act);
		assert (act === exp) else begin
			$display("[FAIL] %s %s: expected %h, actual %h", name, what, exp, act);
			test_errs++;
		end
	endtask

	task automatic check_display(input string name, input digit_t d0, input digit_t d1,
			input digit_t d2);
		digit_t exp [NUM_DIGITS];
		int     waited;
		exp[0] = d0;
		exp[1] = d1;
		exp[2] = d2;
		exp[3] = DIGIT_BLANK;	// unused position
		for (int k = 0; k < NUM_DIGITS; k++) begin
			waited = 0;
			while (seg_choice !== ~(NUM_DIGITS'(1) << k) && waited < SCAN_LIMIT) begin
				@(posedge sys_clk);
				waited++;
			end
			if (waited >= SCAN_LIMIT) begin
				$display("%s: the scan never selected digit %0d", name, k);
				test_errs++;
			end else begin
				check_value(name, $sformatf("digit %0d", k), glyph[exp[k]], seg_number);
			end
		end
	endtask

	task automatic report_test(input string name);
		if (test_errs == 0) begin
			tests_ok++;
			$display("%-12s ok", name);
		end else begin
			tests_bad++;
			$display("%-12s %0d errors", name, test_errs);
		end
	endtask

	initial begin
		int    waited;
		byte_t got;
		key_in = '1;
		cs     = 1'b1;
		sclk   = 1'b1;
		mosi   = 1'b0;
		seed        = 32'h5788;
		n_rows      = 0;
		model_reply = '0;
		model_led   = '0;
		model_disp  = '0;
		tests_ok    = 0;
		tests_bad   = 0;
		glyph = '{8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99, 8'h92, 8'h82, 8'hf8, 8'h80, 8'h90, 8'hff};

		add_row("spi_first", KIND_SPI, 0, 8'd0);
		add_row("spi_7", KIND_SPI, 0, 8'd7);
		add_row("spi_42", KIND_SPI, 0, 8'd42);
		add_row("spi_255", KIND_SPI, 0, 8'd255);
		add_row("key0_on", KIND_KEY, 0, 8'd0);
		add_row("spi_rand0", KIND_SPI, 0, byte_t'($random(seed)));
		add_row("key0_off", KIND_KEY, 0, 8'd0);
		add_row("glitch_6", KIND_GLITCH, 6, 8'd0);
		add_row("key3_on", KIND_KEY, 3, 8'd0);
		add_row("spi_rand1", KIND_SPI, 0, byte_t'($random(seed)));
		add_row("key1_on", KIND_KEY, 1, 8'd0);
		add_row("spi_rand2", KIND_SPI, 0, byte_t'($random(seed)));
		add_row("spi_100", KIND_SPI, 0, 8'd100);
		add_row("spi_rand3", KIND_SPI, 0, byte_t'($random(seed)));

		waited = 0;
		while (sys_rst_n !== 1'b1 && waited < 20) begin
			@(posedge sys_clk);
			waited++;
		end
		test_errs = 0;
		if (waited >= 20) begin
			$display("reset_state: reset was never released");
			test_errs++;
		end
		wait_cycles(4);
		check_value("reset_state", "led", 8'h00, byte_t'(led));
		check_display("reset_state", 4'd0, DIGIT_BLANK, DIGIT_BLANK);
		report_test("reset_state");

		for (int r = 0; r < n_rows; r++) begin
			test_errs = 0;
			case (row_kind[r])
				KIND_SPI: begin
					spi_transfer(row_tx[r], got);
					check_value(row_name[r], "miso", row_miso[r], got);
				end
				KIND_KEY: press_key(row_arg[r]);
				default:  glitch_key(row_arg[r]);
			endcase
			check_value(row_name[r], "led", byte_t'(row_led[r]), byte_t'(led));
			check_display(row_name[r], row_dig[r][0], row_dig[r][1], row_dig[r][2]);
			report_test(row_name[r]);
		end

		$display("%0d ok, %0d with errors", tests_ok, tests_bad);
		if (tests_bad == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// tb_clk_gen: 40 ns system clock and active-low reset for 3 cycles
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic sys_clk,
	output logic sys_rst_n
);
	localparam int HALF_PERIOD = 20;	// ns
	localparam int RST_CYCLES  = 3;

	initial begin
		sys_clk = 1'b0;
		forever #(HALF_PERIOD) sys_clk = ~sys_clk;
	end

	initial begin
		sys_rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge sys_clk);
		sys_rst_n <= 1'b1;	// release on a rising edge
	end

endmodule

`default_nettype wire

// ==== hw/panel_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// panel_top: keys with leds, spi slave with +2 reply,
// decimal display of the last received byte
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module panel_top (
	input  logic                             sys_clk,
	input  logic                             sys_rst_n,
	input  panel_pkg::key_t                  key_in,
	output panel_pkg::key_t                  led,
	input  logic                             cs,
	input  logic                             sclk,
	input  logic                             mosi,
	output logic                             miso,
	output panel_pkg::seg_t                  seg_number,
	output logic [panel_pkg::NUM_DIGITS-1:0] seg_choice
);
	import panel_pkg::*;

	byte_t  rx_data;
	logic   rx_vld;
	byte_t  reply;		// sent back in the next frame
	byte_t  disp_value;
	digit_t dig0;
	digit_t dig1;
	digit_t dig2;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			reply      <= '0;
			disp_value <= '0;
		end else if (rx_vld) begin
			reply      <= rx_data + 8'd2;	// wraps mod 256
			disp_value <= rx_data;
		end
	end

	key_debounce u_key_debounce (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.key_in    (key_in),
		.key_pos   (),		// leds are the only consumer here
		.led       (led)
	);

	spi_slave u_spi_slave (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.tx_data   (reply),
		.rx_data   (rx_data),
		.rx_vld    (rx_vld)
	);

	dec_formatter u_dec_formatter (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.value     (disp_value),
		.dig0      (dig0),
		.dig1      (dig1),
		.dig2      (dig2)
	);

	// digit 3 stays dark
	seg_scan u_seg_scan (
		.sys_clk    (sys_clk),
		.sys_rst_n  (sys_rst_n),
		.dig0       (dig0),
		.dig1       (dig1),
		.dig2       (dig2),
		.dig3       (DIGIT_BLANK),
		.seg_number (seg_number),
		.seg_choice (seg_choice)
	);

endmodule

`default_nettype wire

// ==== hw/seg_scan.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// seg_scan: four-digit multiplexer with private glyph table
// active-low segment pattern and digit select, registered together
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module seg_scan (
	input  logic                             sys_clk,
	input  logic                             sys_rst_n,
	input  panel_pkg::digit_t                dig0,
	input  panel_pkg::digit_t                dig1,
	input  panel_pkg::digit_t                dig2,
	input  panel_pkg::digit_t                dig3,
	output panel_pkg::seg_t                  seg_number,
	output logic [panel_pkg::NUM_DIGITS-1:0] seg_choice
);
	import panel_pkg::*;

	logic [$clog2(SCAN_CYCLES)-1:0] dwell_cnt;
	logic [$clog2(NUM_DIGITS)-1:0]  dig_idx;
	digit_t                         cur_code;

	// gfedcba, low = lit, dp kept dark
	function automatic seg_t seg_decode(input digit_t code);
		case (code)
			4'd0:    seg_decode = 8'hc0;
			4'd1:    seg_decode = 8'hf9;
			4'd2:    seg_decode = 8'ha4;
			4'd3:    seg_decode = 8'hb0;
			4'd4:    seg_decode = 8'h99;
			4'd5:    seg_decode = 8'h92;
			4'd6:    seg_decode = 8'h82;
			4'd7:    seg_decode = 8'hf8;
			4'd8:    seg_decode = 8'h80;
			4'd9:    seg_decode = 8'h90;
			default: seg_decode = 8'hff;	// blank and unused codes
		endcase
	endfunction

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dwell_cnt <= '0;
			dig_idx   <= '0;
		end else if (dwell_cnt == ($clog2(SCAN_CYCLES))'(SCAN_CYCLES - 1)) begin
			dwell_cnt <= '0;
			dig_idx   <= dig_idx + 1'b1;	// wraps 3 -> 0
		end else begin
			dwell_cnt <= dwell_cnt + 1'b1;
		end
	end

	always_comb begin
		case (dig_idx)
			2'd0:    cur_code = dig0;
			2'd1:    cur_code = dig1;
			2'd2:    cur_code = dig2;
			default: cur_code = dig3;
		endcase
	end

	// pattern and select share one register stage
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			seg_number <= seg_decode(4'd0);
			seg_choice <= 4'b1110;
		end else begin
			seg_number <= seg_decode(cur_code);
			seg_choice <= ~(NUM_DIGITS'(1) << dig_idx);
		end
	end

endmodule

`default_nettype wire

// ==== hw/dec_formatter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// dec_formatter: byte to hundreds, tens and units digit codes
// with leading-zero blanking, registered output
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module dec_formatter (
	input  logic              sys_clk,
	input  logic              sys_rst_n,
	input  panel_pkg::byte_t  value,
	output panel_pkg::digit_t dig0,		// units
	output panel_pkg::digit_t dig1,		// tens
	output panel_pkg::digit_t dig2		// hundreds
);
	import panel_pkg::*;

	byte_t  hundreds;
	byte_t  tens;
	byte_t  units;
	digit_t dig1_nxt;
	digit_t dig2_nxt;

	always_comb begin
		hundreds = value / 8'd100;
		tens     = (value / 8'd10) % 8'd10;
		units    = value % 8'd10;
	end

	// blank leading zeros, units always shown
	always_comb begin
		dig2_nxt = (value < 8'd100) ? DIGIT_BLANK : digit_t'(hundreds);
		dig1_nxt = (value < 8'd10) ? DIGIT_BLANK : digit_t'(tens);
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			dig0 <= '0;		// shows "  0"
			dig1 <= DIGIT_BLANK;
			dig2 <= DIGIT_BLANK;
		end else begin
			dig0 <= digit_t'(units);
			dig1 <= dig1_nxt;
			dig2 <= dig2_nxt;
		end
	end

endmodule

`default_nettype wire

// ==== hw/spi_slave.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// spi_slave: mode 3 slave, oversampled in sys_clk
// one byte in and one byte out per chip-select frame
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module spi_slave (
	input  logic             sys_clk,
	input  logic             sys_rst_n,
	input  logic             cs,
	input  logic             sclk,
	input  logic             mosi,
	output logic             miso,
	input  panel_pkg::byte_t tx_data,
	output panel_pkg::byte_t rx_data,
	output logic             rx_vld
);
	import panel_pkg::*;

	logic [1:0] cs_sync;
	logic [1:0] sclk_sync;
	logic [1:0] mosi_sync;
	logic       cs_d;
	logic       sclk_d;
	logic       cs_fall;
	logic       cs_rise;
	logic       sclk_rise;
	logic       sclk_fall;
	logic [3:0] bit_cnt;	// saturates, so long frames stay invalid
	byte_t      rx_shift;
	byte_t      tx_shift;

	// two-flop synchronizers plus one delay stage for edge detect
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			cs_sync   <= '1;
			sclk_sync <= '1;	// mode 3 idles high
			mosi_sync <= '0;
			cs_d      <= 1'b1;
			sclk_d    <= 1'b1;
		end else begin
			cs_sync   <= {cs_sync[0], cs};
			sclk_sync <= {sclk_sync[0], sclk};
			mosi_sync <= {mosi_sync[0], mosi};
			cs_d      <= cs_sync[1];
			sclk_d    <= sclk_sync[1];
		end
	end

	assign cs_fall   = cs_d & ~cs_sync[1];
	assign cs_rise   = ~cs_d & cs_sync[1];
	assign sclk_rise = ~cs_sync[1] & ~sclk_d & sclk_sync[1];
	assign sclk_fall = ~cs_sync[1] & sclk_d & ~sclk_sync[1];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			bit_cnt <= '0;
		end else if (cs_fall) begin
			bit_cnt <= '0;
		end else if (sclk_rise && bit_cnt != 4'hf) begin
			bit_cnt <= bit_cnt + 1'b1;
		end
	end

	// sample on rising sclk, msb first
	always_ff @(posedge sys_clk) begin
		if (sclk_rise)
			rx_shift <= {rx_shift[6:0], mosi_sync[1]};
	end

	// msb goes out at cs fall, the first falling sclk keeps it
	always_ff @(posedge sys_clk) begin
		if (cs_fall)
			tx_shift <= tx_data;
		else if (sclk_fall && bit_cnt != 4'd0)
			tx_shift <= {tx_shift[6:0], 1'b1};
	end

	assign miso = cs_sync[1] | tx_shift[7];	// high while deselected

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_data <= '0;
			rx_vld  <= 1'b0;
		end else begin
			rx_vld <= 1'b0;
			if (cs_rise && bit_cnt == BYTE_BITS[3:0]) begin
				rx_data <= rx_shift;
				rx_vld  <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hw/key_debounce.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// key_debounce: two-flop synchronizer and stability filter per key,
// press pulses and toggled led levels
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module key_debounce (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  panel_pkg::key_t key_in,		// raw, active low
	output panel_pkg::key_t key_pos,	// one pulse per accepted press
	output panel_pkg::key_t led
);
	import panel_pkg::*;

	key_t                 key_meta;
	key_t                 key_sync;
	key_t                 key_state;	// accepted level, 1 = released
	key_t                 key_state_d;
	key_t                 key_fall;
	logic [DEB_CNT_W-1:0] stab_cnt [4];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_meta <= '1;
			key_sync <= '1;
		end else begin
			key_meta <= key_in;
			key_sync <= key_meta;
		end
	end

	// a differing level must hold for DEBOUNCE_CYCLES before it counts
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_state <= '1;
			for (int i = 0; i < 4; i++)
				stab_cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (key_sync[i] == key_state[i]) begin
					stab_cnt[i] <= '0;	// glitch ends, start over
				end else if (stab_cnt[i] == DEB_CNT_W'(DEBOUNCE_CYCLES - 1)) begin
					key_state[i] <= key_sync[i];
					stab_cnt[i]  <= '0;
				end else begin
					stab_cnt[i] <= stab_cnt[i] + 1'b1;
				end
			end
		end
	end

	assign key_fall = key_state_d & ~key_state;	// released -> pressed

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			key_state_d <= '1;
			key_pos     <= '0;
			led         <= '0;
		end else begin
			key_state_d <= key_state;
			key_pos     <= key_fall;
			led         <= led ^ key_fall;	// same cycle as the pulse
		end
	end

endmodule

`default_nettype wire

// ==== hw/panel_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// front-panel controller shared definitions
// data widths, digit codes and timing constants for keys, spi, display
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package panel_pkg;

	// data paths
	typedef logic [7:0] byte_t;		// spi data, display value
	typedef logic [3:0] key_t;		// keys, press pulses, leds
	typedef logic [3:0] digit_t;	// 0..9 decimal, 10 blank
	typedef logic [7:0] seg_t;		// active low, dp + gfedcba

	localparam byte_t  BYTE_BITS   = 8'd8;	// bits per spi frame
	localparam digit_t DIGIT_BLANK = 4'd10;

	// key filter, simulation scale
	localparam int DEBOUNCE_CYCLES = 16;
	localparam int DEB_CNT_W       = 5;

	// display scan
	localparam int SCAN_CYCLES = 8;	// dwell per digit
	localparam int NUM_DIGITS  = 4;

endpackage

`default_nettype wire
